/* Makefile */
SIM = obj_dir/sim_ice51

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_ice51 -Mdir obj_dir -o sim_ice51
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* list.f */
src/ice51_pkg.sv
src/periph_bus_if.sv
src/uart_rx.sv
src/code_store.sv
src/uart_tx_periph.sv
src/cpu_core.sv
src/ice51_top.sv
testbench/tb_clock.sv
testbench/ice51_assertions.sv
testbench/tb_ice51.sv

/* src/code_store.sv */
`timescale 1ns/1ps

module code_store (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx_valid,
   input  ice51_pkg::byte_t      i_rx_data,
   input  ice51_pkg::code_addr_t i_fetch_addr,
   output ice51_pkg::byte_t      o_fetch_data,
   output logic                  o_run
);
   import ice51_pkg::*;

   byte_t      mem [0:2**CODE_AW-1];
   byte_t      len_q;       // program length from the first byte
   code_addr_t wr_ptr;
   logic       len_seen;
   logic       code_wr;
   logic       last_byte;

   assign code_wr   = i_rx_valid & len_seen & ~o_run;
   assign last_byte = (wr_ptr == code_addr_t'(len_q - 8'd1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         len_q    <= '0;
         wr_ptr   <= '0;
         len_seen <= 1'b0;
         o_run    <= 1'b0;
      end else if (i_rx_valid && !len_seen) begin
         len_q    <= i_rx_data;
         len_seen <= 1'b1;
      end else if (code_wr) begin
         wr_ptr <= wr_ptr + 1'b1;
         if (last_byte) o_run <= 1'b1;   // held until reset
      end
   end

   always_ff @(posedge i_clk) begin
      if (code_wr) mem[wr_ptr] <= i_rx_data;
   end

   assign o_fetch_data = mem[i_fetch_addr];   // async read for the core

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_run,
   output ice51_pkg::code_addr_t o_fetch_addr,
   input  ice51_pkg::byte_t      i_fetch_data,
   periph_bus_if.master          bus
);
   import ice51_pkg::*;

   cpu_state_e           state;
   opcode_e              op_dec;     // decode of the byte on the fetch port
   opcode_e              op_q;
   logic [2:0]           rn_q;
   byte_t                imm1_q;
   byte_t                imm2_q;
   code_addr_t           pc;
   code_addr_t           pc_rel;
   byte_t                acc;
   logic                 carry;
   logic [PERIPH_AW-1:0] dptr;
   byte_t                regs [0:7];
   byte_t                rn_val;
   byte_t                rn_dec;
   byte_t                add_src;
   logic [8:0]           sum;
   logic                 two_byte;
   logic                 three_byte;
   logic                 is_movx;
   logic                 apb_access;
   logic                 exec_done;
   logic                 take_jump;

   function automatic opcode_e decode_op(input byte_t b);
      opcode_e op;
      byte_t   base;
      base = {b[7:3], 3'b000};
      if (base inside {ADDAR, MOVAR, MOVRA, DJNZR}) begin
         op = opcode_e'(base);
      end else if (b inside {INCA, DECA, ADDAI, JC, JNC, JZ, JNZ, MOVAI, SJMP,
                             MOVDP, MOVXAD, CLRA, MOVXDA}) begin
         op = opcode_e'(b);
      end else begin
         op = NOP;   // anything unknown runs as a 1 byte nop
      end
      return op;
   endfunction

   ////////////////////
   // decode

   assign op_dec     = decode_op(i_fetch_data);
   assign two_byte   = op_dec inside {MOVAI, ADDAI, SJMP, JZ, JNZ, JC, JNC, DJNZR};
   assign three_byte = (op_dec == MOVDP);

   assign o_fetch_addr = pc;
   assign rn_val       = regs[rn_q];
   assign rn_dec       = rn_val - 8'd1;
   assign add_src      = (op_q == ADDAR) ? rn_val : imm1_q;
   assign sum          = {1'b0, acc} + {1'b0, add_src};

   // pc already points past the instruction here
   assign pc_rel = pc + code_addr_t'({{CODE_AW{imm1_q[7]}}, imm1_q});

   always_comb begin
      case (op_q)
         SJMP:    take_jump = 1'b1;
         JZ:      take_jump = (acc == 8'd0);
         JNZ:     take_jump = (acc != 8'd0);
         JC:      take_jump = carry;
         JNC:     take_jump = ~carry;
         DJNZR:   take_jump = (rn_dec != 8'd0);
         default: take_jump = 1'b0;
      endcase
   end

   ////////////////////
   // apb master

   assign is_movx   = op_q inside {MOVXDA, MOVXAD};
   assign exec_done = ~is_movx | (apb_access & bus.pready);

   assign bus.psel    = (state == EXECUTE) & is_movx;
   assign bus.penable = apb_access;
   assign bus.pwrite  = (op_q == MOVXDA);
   assign bus.paddr   = dptr;
   assign bus.pwdata  = acc;

   ////////////////////
   // sequencer and pc

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= FETCH;
         pc         <= '0;
         op_q       <= NOP;
         rn_q       <= '0;
         apb_access <= 1'b0;
      end else begin
         case (state)
            FETCH: if (i_run) state <= DECODE0;   // held here until loaded
            DECODE0: begin
               op_q  <= op_dec;
               rn_q  <= i_fetch_data[2:0];
               pc    <= pc + 1'b1;
               state <= (two_byte | three_byte) ? DECODE1 : EXECUTE;
            end
            DECODE1: begin
               pc    <= pc + 1'b1;
               state <= (op_q == MOVDP) ? DECODE2 : EXECUTE;
            end
            DECODE2: begin
               pc    <= pc + 1'b1;
               state <= EXECUTE;
            end
            EXECUTE: begin
               if (is_movx && !apb_access) apb_access <= 1'b1;   // setup -> access
               if (exec_done) begin
                  apb_access <= 1'b0;
                  state      <= FETCH;
                  if (take_jump) pc <= pc_rel;
               end
            end
            default: state <= FETCH;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == DECODE1) imm1_q <= i_fetch_data;
      if (state == DECODE2) imm2_q <= i_fetch_data;
   end

   ////////////////////
   // acc, carry, dptr

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (state == EXECUTE && exec_done) begin
         case (op_q)
            MOVAI:  acc <= imm1_q;
            ADDAI, ADDAR: begin
               acc   <= sum[7:0];
               carry <= sum[8];
            end
            MOVAR:  acc <= rn_val;
            INCA:   acc <= acc + 8'd1;   // carry untouched
            DECA:   acc <= acc - 8'd1;
            CLRA:   acc <= '0;
            MOVDP:  dptr <= PERIPH_AW'({imm1_q, imm2_q});   // high byte first
            MOVXAD: acc <= bus.prdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == EXECUTE) begin
         if (op_q == MOVRA) begin
            regs[rn_q] <= acc;
         end else if (op_q == DJNZR) begin
            regs[rn_q] <= rn_dec;
         end
      end
   end

endmodule

/* src/ice51_pkg.sv */
package ice51_pkg;

   ////////////////////
   // widths and timing

   localparam int BIT_CYCLES = 104;                 // clocks per serial bit
   localparam int SAMPLE_W   = $clog2(BIT_CYCLES);
   localparam int CODE_AW    = 8;                   // 256 bytes of code
   localparam int PERIPH_AW  = 16;

   // MOVX targets matched against DPTR
   localparam logic [PERIPH_AW-1:0] UART_STAT_ADDR = 16'h0200;
   localparam logic [PERIPH_AW-1:0] UART_DATA_ADDR = 16'h0201;

   ////////////////////
   // types

   typedef logic [7:0]          byte_t;
   typedef logic [CODE_AW-1:0]  code_addr_t;
   typedef logic [SAMPLE_W-1:0] sample_cnt_t;

   typedef enum logic [2:0] {FETCH, DECODE0, DECODE1, DECODE2, EXECUTE} cpu_state_e;

   // register forms keep rn in the low three bits
   typedef enum logic [7:0] {
      NOP    = 8'h00,
      INCA   = 8'h04,
      DECA   = 8'h14,
      ADDAI  = 8'h24,
      ADDAR  = 8'h28,
      JC     = 8'h40,
      JNC    = 8'h50,
      JZ     = 8'h60,
      JNZ    = 8'h70,
      MOVAI  = 8'h74,
      SJMP   = 8'h80,
      MOVDP  = 8'h90,
      DJNZR  = 8'hD8,
      MOVXAD = 8'hE0,
      CLRA   = 8'hE4,
      MOVAR  = 8'hE8,
      MOVXDA = 8'hF0,
      MOVRA  = 8'hF8
   } opcode_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

/* src/ice51_top.sv */
`timescale 1ns/1ps

module ice51_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);
   import ice51_pkg::*;

   logic       rx_valid;
   byte_t      rx_data;
   logic       run;
   code_addr_t fetch_addr;
   byte_t      fetch_data;

   periph_bus_if bus ();   // core to transmitter

   uart_rx u_rx (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_uart_rx),
      .o_rx_valid (rx_valid),
      .o_rx_data  (rx_data)
   );

   code_store u_code (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx_valid   (rx_valid),
      .i_rx_data    (rx_data),
      .i_fetch_addr (fetch_addr),
      .o_fetch_data (fetch_data),
      .o_run        (run)
   );

   cpu_core u_core (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_run        (run),
      .o_fetch_addr (fetch_addr),
      .i_fetch_data (fetch_data),
      .bus          (bus.master)
   );

   uart_tx_periph u_tx (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .bus    (bus.slave),
      .o_tx   (o_uart_tx)
   );

endmodule

/* src/periph_bus_if.sv */
`timescale 1ns/1ps

interface periph_bus_if;
   import ice51_pkg::*;

   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [PERIPH_AW-1:0] paddr;
   byte_t                pwdata;
   byte_t                prdata;
   logic                 pready;   // low stretches the access phase

   modport master (output psel, penable, pwrite, paddr, pwdata, input prdata, pready);
   modport slave  (input psel, penable, pwrite, paddr, pwdata, output prdata, pready);

endinterface

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_rx,
   output logic             o_rx_valid,
   output ice51_pkg::byte_t o_rx_data
);
   import ice51_pkg::*;

   logic [1:0]  rx_sync;   // two flop resync
   logic        rx_line;
   rx_state_e   state;
   sample_cnt_t cnt;
   logic [2:0]  bit_idx;
   byte_t       shift;
   logic        half_bit;
   logic        full_bit;

   assign rx_line  = rx_sync[1];
   assign half_bit = (cnt == sample_cnt_t'(BIT_CYCLES/2 - 1));
   assign full_bit = (cnt == sample_cnt_t'(BIT_CYCLES - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;   // idle line is high
      end else begin
         rx_sync <= {rx_sync[0], i_rx};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               cnt     <= '0;
               bit_idx <= '0;
               if (!rx_line) state <= RX_START;
            end
            RX_START: begin
               if (half_bit) begin
                  cnt   <= '0;
                  // glitch shorter than half a bit goes back to idle
                  state <= rx_line ? RX_IDLE : RX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (full_bit) begin
                  cnt   <= '0;
                  state <= RX_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb first, sampled mid-bit
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && full_bit) shift <= {rx_line, shift[7:1]};
   end

   assign o_rx_valid = (state == RX_STOP) & full_bit & rx_line;   // framing check
   assign o_rx_data  = shift;

endmodule

/* src/uart_tx_periph.sv */
`timescale 1ns/1ps

module uart_tx_periph (
   input  logic        i_clk,
   input  logic        i_nrst,
   periph_bus_if.slave bus,
   output logic        o_tx
);
   import ice51_pkg::*;

   tx_state_e   state;
   sample_cnt_t cnt;
   logic [3:0]  bit_cnt;   // 8 data bits then stop
   byte_t       shift;
   logic        busy;
   logic        sel_stat;
   logic        sel_data;
   logic        wr_accept;
   logic        bit_end;

   ////////////////////
   // apb side

   assign sel_stat = (bus.paddr == UART_STAT_ADDR);
   assign sel_data = (bus.paddr == UART_DATA_ADDR);
   assign busy     = (state != TX_IDLE);
   assign bit_end  = (cnt == sample_cnt_t'(BIT_CYCLES - 1));

   // data writes stall while a byte is still on the line
   assign bus.pready = ~(bus.pwrite & sel_data & busy);
   assign bus.prdata = (sel_stat & ~bus.pwrite) ? {7'd0, busy} : '0;
   assign wr_accept  = bus.psel & bus.penable & bus.pwrite & sel_data & ~busy;

   ////////////////////
   // serial side

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (wr_accept) state <= TX_START;
            end
            TX_START: begin
               if (bit_end) begin
                  cnt   <= '0;
                  state <= TX_SEND;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_SEND: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE;   // stop bit done
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // ones shift in behind the data, giving the stop bit
   always_ff @(posedge i_clk) begin
      if (wr_accept) begin
         shift <= bus.pwdata;
      end else if (state == TX_SEND && bit_end) begin
         shift <= {1'b1, shift[7:1]};
      end
   end

   always_comb begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_SEND:  o_tx = shift[0];
         default:  o_tx = 1'b1;
      endcase
   end

endmodule

/* testbench/ice51_assertions.sv */
`timescale 1ns/1ps

module ice51_assertions (
   input logic                                i_clk,
   input logic                                i_nrst,
   input logic                                i_psel,
   input logic                                i_penable,
   input logic                                i_pwrite,
   input logic                                i_pready,
   input logic [ice51_pkg::PERIPH_AW-1:0]     i_paddr,
   input ice51_pkg::byte_t                    i_pwdata,
   input logic                                i_tx
);
   import ice51_pkg::*;

   logic data_wr_done;   // completed write to the data register

   assign data_wr_done = i_psel & i_penable & i_pready & i_pwrite
                         & (i_paddr == UART_DATA_ADDR);

   // access phase only after a setup cycle
   penable_after_setup: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_penable) |-> $past(i_psel))
      else $error("apb penable rose without a setup cycle");

   penable_needs_psel: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_penable |-> i_psel)
      else $error("apb penable high with psel low");

   // a stalled transfer keeps address and data
   stable_while_stalled: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_penable && !i_pready) |=> ($stable(i_paddr) && $stable(i_pwdata)))
      else $error("apb paddr or pwdata changed during a stalled access");

   // an accepted write finds the transmitter idle with the line high
   line_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      data_wr_done |-> i_tx)
      else $error("transmit line low while the transmitter is idle");

   start_bit_follows: assert property (@(posedge i_clk) disable iff (!i_nrst)
      data_wr_done |=> !i_tx)
      else $error("no start bit in the cycle after an accepted write");

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always #20 o_clk = ~o_clk;   // 40 ns period

endmodule

/* testbench/tb_ice51.sv */
`timescale 1ns/1ps

module tb_ice51;
   import ice51_pkg::*;

   // some 135k cycles of frames and settle time are needed
   localparam int WATCHDOG_CYCLES = 2000 * 10 * BIT_CYCLES;

   logic   clk;
   logic   nrst;
   logic   uart_rx;
   logic   uart_tx;
   integer seed;
   int     errors;
   int     tests_run;
   int     tests_failed;
   byte_t  prog_q [$];   // program bytes without the length byte
   byte_t  exp_q [$];
   byte_t  rx_q [$];     // bytes decoded from o_uart_tx

   tb_clock u_clk (.o_clk(clk));

   ice51_top i_dut (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   bind uart_tx_periph ice51_assertions u_sva (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_psel    (bus.psel),
      .i_penable (bus.penable),
      .i_pwrite  (bus.pwrite),
      .i_pready  (bus.pready),
      .i_paddr   (bus.paddr),
      .i_pwdata  (bus.pwdata),
      .i_tx      (o_tx)
   );

   ////////////////////
   // uart driver

   task automatic drive_rx_bit(input logic v);
      @(posedge clk);
      #2 uart_rx = v;
      repeat (BIT_CYCLES - 1) @(posedge clk);
   endtask

   task automatic send_byte(input byte_t b);
      drive_rx_bit(1'b0);   // start
      for (int i = 0; i < 8; i++) begin
         drive_rx_bit(b[i]);
      end
      drive_rx_bit(1'b1);   // stop
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #2;
      nrst    = 1'b0;
      uart_rx = 1'b1;
      repeat (10) @(posedge clk);
      #2 nrst = 1'b1;
      rx_q.delete();
   endtask

   ////////////////////
   // uart monitor sampling on the falling clock edge

   initial begin : uart_monitor
      byte_t b;
      forever begin
         @(negedge clk);
         if (nrst && !uart_tx) begin
            repeat (BIT_CYCLES / 2) @(negedge clk);   // middle of start bit
            if (uart_tx) begin
               $display("monitor: start bit on o_uart_tx did not stay low");
               errors++;
            end else begin
               for (int i = 0; i < 8; i++) begin
                  repeat (BIT_CYCLES) @(negedge clk);
                  b[i] = uart_tx;
               end
               repeat (BIT_CYCLES) @(negedge clk);
               if (!uart_tx) begin
                  $display("monitor: stop bit on o_uart_tx was low, frame dropped");
                  errors++;
               end else begin
                  rx_q.push_back(b);
               end
            end
         end
      end
   end

   ////////////////////
   // load, run and compare

   task automatic run_program(input string name);
      int start_errors;
      int limit;
      int waited;
      start_errors = errors;
      reset_dut();
      send_byte(byte_t'(prog_q.size()));
      foreach (prog_q[i]) begin
         send_byte(prog_q[i]);
      end
      limit  = (exp_q.size() + 2) * 10 * BIT_CYCLES;
      waited = 0;
      while (rx_q.size() < exp_q.size() && waited < limit) begin
         @(posedge clk);
         waited++;
      end
      repeat (12 * BIT_CYCLES) @(posedge clk);   // room for a stray extra frame
      if (rx_q.size() < exp_q.size()) begin
         $display("%s: only %0d of %0d bytes arrived on o_uart_tx", name, rx_q.size(),
                  exp_q.size());
         errors++;
      end
      if (rx_q.size() > exp_q.size()) begin
         $display("%s: %0d unexpected extra bytes on o_uart_tx", name,
                  rx_q.size() - exp_q.size());
         errors++;
      end
      for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
         if (rx_q[i] !== exp_q[i]) begin
            $display("ERROR: %s o_uart_tx byte %0d expected 0x%02h got 0x%02h", name, i,
                     exp_q[i], rx_q[i]);
            errors++;
         end
      end
      tests_run++;
      if (errors == start_errors) begin
         $display("%-18s ok", name);
      end else begin
         $display("%-18s FAIL", name);
         tests_failed++;
      end
   endtask

   ////////////////////
   // directed tests

   task automatic load_and_transmit();
      prog_q = {8'h90, 8'h02, 8'h01, 8'h74, 8'h55, 8'hF0, 8'h80, 8'hFE};
      exp_q  = {8'h55};
      run_program("load_and_transmit");
   endtask

   // 0xF0 + 0x20 sets carry, JC skips the clear
   task automatic arith_carry();
      prog_q = {8'h90, 8'h02, 8'h01, 8'h74, 8'hF0, 8'h24, 8'h20, 8'h40, 8'h02,
                8'h74, 8'h00, 8'h04, 8'h14, 8'h14, 8'hF0, 8'h80, 8'hFE};
      exp_q  = {8'h0F};
      run_program("arith_carry");
   endtask

   // loop adds 3+2+1, then JZ falls through and JNZ skips the clear
   task automatic register_loop();
      prog_q = {8'h90, 8'h02, 8'h01, 8'h74, 8'h03, 8'hFA, 8'hE4, 8'h2A, 8'hDA, 8'hFD,
                8'hF0, 8'h60, 8'h01, 8'h04, 8'h70, 8'h02, 8'h74, 8'h00, 8'hF0,
                8'h80, 8'hFE};
      exp_q  = {8'h06, 8'h07};
      run_program("register_loop");
   endtask

   task automatic back_pressure();
      prog_q = {8'h90, 8'h02, 8'h01, 8'h74, 8'h11, 8'hF0, 8'h74, 8'h22, 8'hF0,
                8'h74, 8'h33, 8'hF0, 8'h80, 8'hFE};
      exp_q  = {8'h11, 8'h22, 8'h33};
      run_program("back_pressure");
   endtask

   // status is read while 0x3C is in flight, then polled down to zero
   task automatic status_read();
      prog_q = {8'h90, 8'h02, 8'h01, 8'h74, 8'h3C, 8'hF0,
                8'h90, 8'h02, 8'h00, 8'hE0,
                8'h90, 8'h02, 8'h01, 8'hF0,
                8'h90, 8'h02, 8'h00, 8'hE0, 8'h70, 8'hFD,
                8'h90, 8'h02, 8'h01, 8'h74, 8'hA5, 8'hF0, 8'h80, 8'hFE};
      exp_q  = {8'h3C, 8'h01, 8'hA5};
      run_program("status_read");
   endtask

   task automatic random_sum();
      byte_t rnd [4];
      byte_t sum;
      sum = 8'h00;
      for (int i = 0; i < 4; i++) begin
         rnd[i] = byte_t'($random(seed));
         sum    = sum + rnd[i];   // wraps mod 256
      end
      prog_q = {8'h90, 8'h02, 8'h01, 8'hE4, 8'h24, rnd[0], 8'h24, rnd[1],
                8'h24, rnd[2], 8'h24, rnd[3], 8'hF0, 8'h80, 8'hFE};
      exp_q  = {sum};
      run_program("random_sum");
   endtask

   ////////////////////
   // main flow and watchdog

   initial begin
      nrst         = 1'b0;
      uart_rx      = 1'b1;
      seed         = 32'he00a5d46;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      load_and_transmit();
      arith_carry();
      register_loop();
      back_pressure();
      status_read();
      random_sum();
      $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
               errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: simulation ran out of time before the tests finished");
      $display("Test failures found");
      $finish;
   end

endmodule
